// File: Makefile
TOP = tb_mem_ctl

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing -f flist.f --top-module mem_ctl

clean:
	rm -rf obj_dir sim.log

// File: data_unit.sv
// Data access decode and sizing
`timescale 1ns/1ps

module data_unit
    import mem_ctl_pkg::*;
#(
    parameter logic [7:0] FLASH_BASE = 8'h00,
    parameter logic [7:0] PSRAM_BASE = 8'h01
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic [31:0]  mem_addr,
    input  logic [31:0]  mem_wdata,
    input  mem_size_e    mem_flag,
    input  logic         mem_we,
    input  logic         mem_re,
    output logic [31:0]  mem_rdata,
    output logic         mem_ready,
    mem_req_if.requester data
);
    localparam logic [1:0] DU_IDLE  = 2'd0;
    localparam logic [1:0] DU_LOCAL = 2'd1;
    localparam logic [1:0] DU_ISSUE = 2'd2;
    localparam logic [1:0] DU_BUSY  = 2'd3;

    logic [1:0]  state;
    logic        req_q;
    logic        we_q;
    mem_target_e target_q;
    spi_addr_t   addr_q;
    byte_cnt_t   len_q;
    spi_word_u   wdata_q;
    logic        hit_flash;
    logic        hit_psram;
    byte_cnt_t   len_d;

    assign hit_flash = (mem_addr[31:24] == FLASH_BASE);
    assign hit_psram = (mem_addr[31:24] == PSRAM_BASE);

    // Signed and unsigned sizes move the same number of bytes
    always_comb begin
        case (mem_flag)
            size_byte, size_byte_u: len_d = 3'd1;
            size_half, size_half_u: len_d = 3'd2;
            default:                len_d = 3'd4;
        endcase
    end

    assign data.req    = req_q;
    assign data.we     = we_q;
    assign data.target = target_q;
    assign data.addr   = addr_q;
    assign data.len    = len_q;
    assign data.wdata  = wdata_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= DU_IDLE;
            req_q     <= 1'b0;
            mem_ready <= 1'b0;
        end else begin
            mem_ready <= 1'b0;
            case (state)
                DU_IDLE: begin
                    if (mem_re || mem_we) begin
                        state <= (hit_flash || hit_psram) ? DU_ISSUE : DU_LOCAL;
                    end
                end
                // Unmapped, answer without touching the bus
                DU_LOCAL: begin
                    mem_ready <= 1'b1;
                    state     <= DU_IDLE;
                end
                // Previous handshake may still be closing
                DU_ISSUE: begin
                    if (!data.ack) begin
                        req_q <= 1'b1;
                        state <= DU_BUSY;
                    end
                end
                default: begin
                    if (data.ack) begin
                        req_q     <= 1'b0;
                        mem_ready <= 1'b1;
                        state     <= DU_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DU_IDLE && (mem_re || mem_we)) begin
            we_q     <= mem_we;
            target_q <= hit_flash ? target_flash : target_psram;
            addr_q   <= mem_addr[23:0];
            len_q    <= len_d;
            // Low byte sits at the lowest address
            wdata_q.word <= mem_wdata;
        end
        if (state == DU_LOCAL) begin
            mem_rdata <= '0;
        end else if (state == DU_BUSY && data.ack) begin
            case (len_q)
                3'd1:    mem_rdata <= {24'h0, data.rdata.bytes[0]};
                3'd2:    mem_rdata <= {16'h0, data.rdata.bytes[1], data.rdata.bytes[0]};
                default: mem_rdata <= data.rdata.word;
            endcase
        end
    end

endmodule

// File: fetch_unit.sv
// Instruction word fetch
`timescale 1ns/1ps

module fetch_unit
    import mem_ctl_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  spi_addr_t    instr_addr,
    output logic [31:0]  instr_data,
    output logic         instr_ready,
    mem_req_if.requester fetch
);
    logic      valid;
    spi_addr_t tag;
    spi_addr_t addr_q;
    logic      req_q;
    logic      miss;

    assign miss        = !valid || (tag != instr_addr);
    assign instr_ready = !miss;

    // Always a full word from flash
    assign fetch.req    = req_q;
    assign fetch.we     = 1'b0;
    assign fetch.target = target_flash;
    assign fetch.addr   = addr_q;
    assign fetch.len    = 3'd4;
    assign fetch.wdata  = '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid  <= 1'b0;
            tag    <= '0;
            addr_q <= '0;
            req_q  <= 1'b0;
        end else if (req_q) begin
            if (fetch.ack) begin
                valid <= 1'b1;
                tag   <= addr_q;
                req_q <= 1'b0;
            end
        end else if (miss && !fetch.ack) begin
            // New address, or the core moved on during the last fetch
            req_q  <= 1'b1;
            addr_q <= instr_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (req_q && fetch.ack) begin
            instr_data <= fetch.rdata.word;
        end
    end

endmodule

// File: flist.f
mem_ctl_pkg.sv
mem_req_if.sv
fetch_unit.sv
data_unit.sv
mem_arbiter.sv
qspi_master.sv
mem_ctl.sv
qspi_mem_model.sv
tb_mem_ctl.sv

// File: mem_arbiter.sv
// Data over fetch bus arbiter
`timescale 1ns/1ps

module mem_arbiter
    import mem_ctl_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    mem_req_if.server    fetch,
    mem_req_if.server    data,
    mem_req_if.requester bus,
    output logic         abort,
    output logic         flash_cs_n,
    output logic         ram_cs_n,
    input  logic         bus_cs_n
);
    localparam logic [1:0] ARB_IDLE  = 2'd0;
    localparam logic [1:0] ARB_BUSY  = 2'd1;
    localparam logic [1:0] ARB_ABORT = 2'd2;

    logic [1:0] state;
    logic       grant_data;
    logic       sel_req;
    logic       serving;

    assign sel_req = grant_data ? data.req : fetch.req;
    assign serving = (state == ARB_BUSY);

    // Fields follow the granted side
    always_comb begin
        if (grant_data) begin
            bus.we     = data.we;
            bus.target = data.target;
            bus.addr   = data.addr;
            bus.len    = data.len;
            bus.wdata  = data.wdata;
        end else begin
            bus.we     = fetch.we;
            bus.target = fetch.target;
            bus.addr   = fetch.addr;
            bus.len    = fetch.len;
            bus.wdata  = fetch.wdata;
        end
    end

    // Request stays up through the abort cycle, then drops with it
    assign bus.req     = (state != ARB_IDLE) && sel_req;
    assign abort       = (state == ARB_ABORT);
    assign data.ack    = serving && grant_data && bus.ack;
    assign fetch.ack   = serving && !grant_data && bus.ack;
    assign data.rdata  = bus.rdata;
    assign fetch.rdata = bus.rdata;

    assign flash_cs_n = (bus.target == target_flash) ? bus_cs_n : 1'b1;
    assign ram_cs_n   = (bus.target == target_psram) ? bus_cs_n : 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ARB_IDLE;
            grant_data <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (data.req) begin
                        grant_data <= 1'b1;
                        state      <= ARB_BUSY;
                    end else if (fetch.req) begin
                        grant_data <= 1'b0;
                        state      <= ARB_BUSY;
                    end
                end
                ARB_BUSY: begin
                    if (!sel_req && !bus.ack) begin
                        state <= ARB_IDLE;
                    end else if (!grant_data && fetch.req && data.req
                                 && !bus.ack && !bus_cs_n) begin
                        // Only a fetch with chip select low is cut short
                        // Fetch keeps its req and is granted again later
                        state <= ARB_ABORT;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

endmodule

// File: mem_ctl.sv
// Flash and PSRAM memory controller
`timescale 1ns/1ps

module mem_ctl
    import mem_ctl_pkg::*;
#(
    parameter logic [7:0] FLASH_BASE   = 8'h00,
    parameter logic [7:0] PSRAM_BASE   = 8'h01,
    parameter int         DUMMY_CYCLES = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    // Instruction side
    input  logic [31:0] instr_addr,
    output logic [31:0] instr_data,
    output logic        instr_ready,
    // Data side
    input  logic [31:0] mem_addr,
    input  logic [31:0] mem_wdata,
    input  mem_size_e   mem_flag,
    input  logic        mem_we,
    input  logic        mem_re,
    output logic [31:0] mem_rdata,
    output logic        mem_ready,
    // Shared quad SPI pins
    output logic        flash_cs_n,
    output logic        ram_cs_n,
    output logic        spi_sclk,
    input  logic [3:0]  spi_io_in,
    output logic [3:0]  spi_io_out,
    output logic [3:0]  spi_io_oe
);
    logic abort;
    logic bus_cs_n;

    mem_req_if fetch_if ();
    mem_req_if data_if ();
    mem_req_if bus_if ();

    // Flash is addressed with the low 24 bits only
    fetch_unit u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_addr  (instr_addr[23:0]),
        .instr_data  (instr_data),
        .instr_ready (instr_ready),
        .fetch       (fetch_if.requester)
    );

    data_unit #(
        .FLASH_BASE (FLASH_BASE),
        .PSRAM_BASE (PSRAM_BASE)
    ) u_data (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_flag  (mem_flag),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready),
        .data      (data_if.requester)
    );

    mem_arbiter u_arb (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch      (fetch_if.server),
        .data       (data_if.server),
        .bus        (bus_if.requester),
        .abort      (abort),
        .flash_cs_n (flash_cs_n),
        .ram_cs_n   (ram_cs_n),
        .bus_cs_n   (bus_cs_n)
    );

    qspi_master #(
        .DUMMY_CYCLES (DUMMY_CYCLES)
    ) u_qspi (
        .clk    (clk),
        .rst_n  (rst_n),
        .bus    (bus_if.server),
        .abort  (abort),
        .cs_n   (bus_cs_n),
        .sclk   (spi_sclk),
        .io_in  (spi_io_in),
        .io_out (spi_io_out),
        .io_oe  (spi_io_oe)
    );

endmodule

// File: mem_ctl_pkg.sv
// Memory controller shared types
package mem_ctl_pkg;

    // Device byte address on the SPI bus
    typedef logic [23:0] spi_addr_t;

    // One bus word, seen by the core or as bytes in wire order
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] bytes;
    } spi_word_u;

    // Transfer length in bytes: 1, 2 or 4
    typedef logic [2:0] byte_cnt_t;

    typedef enum logic {
        target_flash = 1'b0,
        target_psram = 1'b1
    } mem_target_e;

    // Load/store funct3 values
    typedef enum logic [2:0] {
        size_byte   = 3'b000,
        size_half   = 3'b001,
        size_word   = 3'b010,
        size_byte_u = 3'b100,
        size_half_u = 3'b101
    } mem_size_e;

    // Quad SPI commands
    localparam logic [7:0] qspi_cmd_read  = 8'heb;
    localparam logic [7:0] qspi_cmd_write = 8'h38;

endpackage

// File: mem_req_if.sv
// Four-phase memory request link
`timescale 1ns/1ps

interface mem_req_if
    import mem_ctl_pkg::*;
();
    logic        req;
    logic        we;
    mem_target_e target;
    spi_addr_t   addr;
    byte_cnt_t   len;
    spi_word_u   wdata;
    spi_word_u   rdata;
    logic        ack;

    // Request side holds the fields stable while req is high
    modport requester (
        output req, we, target, addr, len, wdata,
        input  rdata, ack
    );

    modport server (
        input  req, we, target, addr, len, wdata,
        output rdata, ack
    );

endinterface

// File: qspi_master.sv
// Quad SPI transfer engine
`timescale 1ns/1ps

module qspi_master
    import mem_ctl_pkg::*;
#(
    parameter int DUMMY_CYCLES = 4
) (
    input  logic       clk,
    input  logic       rst_n,
    mem_req_if.server  bus,
    input  logic       abort,
    output logic       cs_n,
    output logic       sclk,
    input  logic [3:0] io_in,
    output logic [3:0] io_out,
    output logic [3:0] io_oe
);
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_XFER = 2'd1;
    localparam logic [1:0] ST_END  = 2'd2;
    localparam logic [1:0] ST_WAIT = 2'd3;

    logic [1:0]  state;
    logic        ack_q;
    logic [7:0]  nib;
    logic [63:0] sr;
    spi_word_u   rx;
    logic [7:0]  data_start;
    logic [7:0]  last_nib;
    logic [7:0]  dnib;

    // Period index where data begins, reads add the dummy periods
    assign data_start = bus.we ? 8'd8 : 8'(8 + DUMMY_CYCLES);
    assign last_nib   = data_start + {4'd0, bus.len, 1'b0} - 8'd1;
    assign dnib       = nib - data_start;

    assign io_out    = sr[63:60];
    assign io_oe     = (state == ST_XFER && (nib < 8'd8 || bus.we)) ? 4'hf : 4'h0;
    assign bus.ack   = ack_q;
    assign bus.rdata = rx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            cs_n  <= 1'b1;
            sclk  <= 1'b0;
            ack_q <= 1'b0;
            nib   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (bus.req && !abort) begin
                        cs_n  <= 1'b0;
                        nib   <= '0;
                        state <= ST_XFER;
                    end
                end
                ST_XFER: begin
                    if (abort) begin
                        cs_n  <= 1'b1;
                        sclk  <= 1'b0;
                        state <= ST_WAIT;
                    end else if (!sclk) begin
                        sclk <= 1'b1;
                    end else begin
                        sclk <= 1'b0;
                        if (nib == last_nib) begin
                            cs_n  <= 1'b1;
                            state <= ST_END;
                        end else begin
                            nib <= nib + 8'd1;
                        end
                    end
                end
                // Aborted transfers never raise ack
                ST_END: begin
                    ack_q <= !abort;
                    state <= ST_WAIT;
                end
                default: begin
                    if (!bus.req) begin
                        ack_q <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Shift out on the falling edge, sample on the rising edge
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && bus.req) begin
            sr <= {(bus.we ? qspi_cmd_write : qspi_cmd_read), bus.addr,
                   bus.wdata.bytes[0], bus.wdata.bytes[1],
                   bus.wdata.bytes[2], bus.wdata.bytes[3]};
            rx <= '0;
        end else if (state == ST_XFER && sclk) begin
            sr <= {sr[59:0], 4'h0};
        end else if (state == ST_XFER && !bus.we && nib >= data_start) begin
            // High nibble first within each byte
            if (!dnib[0]) begin
                rx.bytes[dnib[2:1]][7:4] <= io_in;
            end else begin
                rx.bytes[dnib[2:1]][3:0] <= io_in;
            end
        end
    end

endmodule

// File: qspi_mem_model.sv
// Quad SPI flash and PSRAM device
`timescale 1ns/1ps

module qspi_mem_model
    import mem_ctl_pkg::*;
#(
    parameter int DUMMY_CYCLES = 4
) (
    input  logic       sclk,
    input  logic       flash_cs_n,
    input  logic       ram_cs_n,
    input  logic [3:0] io_in,
    output logic [3:0] io_out
);
    logic [7:0] flash_mem [0:4095];
    logic [7:0] ram_mem [0:4095];
    logic       cs_n;
    int         cnt;
    int         off;
    logic [7:0] cmd;
    spi_addr_t  addr;
    logic [3:0] hi_nib;
    logic [7:0] rd_byte;

    assign cs_n = flash_cs_n && ram_cs_n;

    // Flash pattern on the low address byte, PSRAM fill on the whole address
    initial begin
        for (int a = 0; a < 4096; a++) begin
            flash_mem[a] = 8'(a) ^ 8'ha5;
            ram_mem[a]   = 8'(a ^ (a >> 4)) ^ 8'h3c;
        end
    end

    // Count rising edges and capture command, address and write data
    always @(posedge sclk or posedge cs_n) begin
        if (cs_n) begin
            cnt <= 0;
        end else begin
            if (cnt < 2) begin
                cmd <= {cmd[3:0], io_in};
            end else if (cnt < 8) begin
                addr <= {addr[19:0], io_in};
            end else if (cmd == qspi_cmd_write) begin
                if ((cnt % 2) == 0) begin
                    hi_nib <= io_in;
                end else if (!ram_cs_n) begin
                    ram_mem[addr[11:0] + 12'((cnt - 8) / 2)] <= {hi_nib, io_in};
                end
            end
            cnt <= cnt + 1;
        end
    end

    // Next read nibble goes out while sclk is low
    always @(negedge sclk) begin
        if (!cs_n && cmd == qspi_cmd_read && cnt >= 8 + DUMMY_CYCLES) begin
            off = cnt - 8 - DUMMY_CYCLES;
            if (!ram_cs_n) begin
                rd_byte = ram_mem[addr[11:0] + 12'(off / 2)];
            end else begin
                rd_byte = flash_mem[addr[11:0] + 12'(off / 2)];
            end
            io_out <= ((off % 2) == 0) ? rd_byte[7:4] : rd_byte[3:0];
        end
    end

endmodule

// File: tb_mem_ctl.sv
// Memory controller testbench
`timescale 1ns/1ps

module tb_mem_ctl
    import mem_ctl_pkg::*;
();
    localparam int TIMEOUT = 500;
    localparam int DUMMY   = 4;

    logic        clk;
    logic        rst_n;
    logic [31:0] instr_addr;
    logic [31:0] instr_data;
    logic        instr_ready;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    mem_size_e   mem_flag;
    logic        mem_we;
    logic        mem_re;
    logic [31:0] mem_rdata;
    logic        mem_ready;
    logic        flash_cs_n;
    logic        ram_cs_n;
    logic        spi_sclk;
    logic [3:0]  spi_io_in;
    logic [3:0]  spi_io_out;
    logic [3:0]  spi_io_oe;

    // Shadow copy of the PSRAM contents
    logic [7:0]  shadow [0:4095];
    logic [31:0] rng;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          failed_tests = 0;
    int          test_start = 0;
    int          cs_errors = 0;
    int          cs_busy = 0;

    mem_ctl #(
        .FLASH_BASE   (8'h00),
        .PSRAM_BASE   (8'h01),
        .DUMMY_CYCLES (DUMMY)
    ) UUT (.*);

    qspi_mem_model #(
        .DUMMY_CYCLES (DUMMY)
    ) device (
        .sclk       (spi_sclk),
        .flash_cs_n (flash_cs_n),
        .ram_cs_n   (ram_cs_n),
        .io_in      (spi_io_out),
        .io_out     (spi_io_in)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] flash_byte(input logic [31:0] a);
        return a[7:0] ^ 8'ha5;
    endfunction

    // Little-endian word with the lowest address in the low byte
    function automatic logic [31:0] flash_word(input logic [31:0] a);
        return {flash_byte(a + 32'd3), flash_byte(a + 32'd2),
                flash_byte(a + 32'd1), flash_byte(a)};
    endfunction

    function automatic int size_bytes(input mem_size_e f);
        case (f)
            size_byte, size_byte_u: return 1;
            size_half, size_half_u: return 2;
            default:                return 4;
        endcase
    endfunction

    function automatic mem_size_e pick_size(input logic [31:0] r);
        case (r % 5)
            0:       return size_byte;
            1:       return size_half;
            2:       return size_word;
            3:       return size_byte_u;
            default: return size_half_u;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("Error: %s", what);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int n);
        tests++;
        if (n != 0) begin
            failed_tests++;
        end
        $display("test %-14s errors %0d", name, n);
        test_start = errors;
    endtask

    task automatic wait_instr(output logic ok);
        int n;
        n = 0;
        @(negedge clk);
        while (!instr_ready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        ok = instr_ready;
    endtask

    // One-cycle request pulse followed by a wait for mem_ready
    task automatic data_access(input logic we, input logic [31:0] addr,
                               input logic [31:0] wdata, input mem_size_e flag,
                               output logic [31:0] rdata, output int cycles);
        mem_addr  = addr;
        mem_wdata = wdata;
        mem_flag  = flag;
        mem_we    = we;
        mem_re    = !we;
        cycles    = 1;
        @(negedge clk);
        mem_we = 1'b0;
        mem_re = 1'b0;
        while (!mem_ready && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        check_true(mem_ready, $sformatf("mem_ready never rose for access at 0x%08h", addr));
        rdata = mem_rdata;
    endtask

    task automatic psram_access(input logic we);
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic [31:0] exp;
        mem_size_e   flag;
        int          n;
        int          cycles;
        rng   = xorshift32(rng);
        flag  = pick_size(rng);
        n     = size_bytes(flag);
        // Small window so that loads often read back earlier stores
        addr  = {8'h01, 18'h0, rng[17:12] & ~6'(n - 1)};
        rng   = xorshift32(rng);
        wdata = rng;
        data_access(we, addr, wdata, flag, rdata, cycles);
        exp = '0;
        for (int i = 0; i < n; i++) begin
            if (we) begin
                shadow[addr[11:0] + 12'(i)] = wdata[8*i +: 8];
            end else begin
                exp[8*i +: 8] = shadow[addr[11:0] + 12'(i)];
            end
        end
        if (!we) begin
            check_value("mem_rdata", rdata, exp);
        end
    endtask

    // Chip selects must never be low together
    always @(negedge clk) begin
        if (rst_n) begin
            if (!flash_cs_n || !ram_cs_n) begin
                cs_busy++;
            end
            assert (flash_cs_n || ram_cs_n) else begin
                $display("Error: flash and PSRAM chip selects both low at %0t", $time);
                errors++;
                cs_errors++;
            end
        end
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] rdata;
        logic [31:0] exp;
        mem_size_e   flag;
        logic        ok;
        int          n;
        int          cycles;
        int          busy;

        rst_n      = 1'b0;
        instr_addr = '0;
        mem_addr   = '0;
        mem_wdata  = '0;
        mem_flag   = size_word;
        mem_we     = 1'b0;
        mem_re     = 1'b0;
        rng        = 32'd47;
        for (int a = 0; a < 4096; a++) begin
            shadow[a] = 8'(a ^ (a >> 4)) ^ 8'h3c;
        end
        repeat (4) @(negedge clk);

        check_value("flash_cs_n", 32'(flash_cs_n), 32'h1);
        check_value("ram_cs_n", 32'(ram_cs_n), 32'h1);
        check_value("spi_sclk", 32'(spi_sclk), 32'h0);
        check_value("spi_io_oe", 32'(spi_io_oe), 32'h0);
        check_value("instr_ready", 32'(instr_ready), 32'h0);
        check_value("mem_ready", 32'(mem_ready), 32'h0);
        end_test("reset", errors - test_start);
        rst_n = 1'b1;

        for (int k = 0; k < 20; k++) begin
            rng = xorshift32(rng);
            instr_addr = {8'h00, rng[23:2], 2'b00};
            wait_instr(ok);
            check_true(ok, "instr_ready never rose after an address change");
            check_value("instr_data", instr_data, flash_word(instr_addr));
        end
        end_test("fetch", errors - test_start);

        for (int k = 0; k < 60; k++) begin
            rng = xorshift32(rng);
            psram_access(rng[0]);
        end
        end_test("store_load", errors - test_start);

        for (int k = 0; k < 12; k++) begin
            rng  = xorshift32(rng);
            flag = pick_size(rng);
            n    = size_bytes(flag);
            addr = {8'h00, rng[31:8] & ~24'(n - 1)};
            data_access(1'b0, addr, 32'h0, flag, rdata, cycles);
            exp = '0;
            for (int i = 0; i < n; i++) begin
                exp[8*i +: 8] = flash_byte(addr + 32'(i));
            end
            check_value("mem_rdata", rdata, exp);
        end
        end_test("flash_read", errors - test_start);

        // Top byte 8x matches neither region
        for (int k = 0; k < 6; k++) begin
            rng  = xorshift32(rng);
            addr = {4'h8, rng[27:0]};
            busy = cs_busy;
            data_access(rng[0], addr, rng, pick_size(rng), rdata, cycles);
            check_value("mem_rdata", rdata, 32'h0);
            check_value("mem_ready latency", 32'(cycles), 32'd2);
            check_true(busy == cs_busy, "a chip select fell for an unmapped access");
        end
        end_test("unmapped", errors - test_start);

        for (int k = 0; k < 8; k++) begin
            rng = xorshift32(rng);
            instr_addr = instr_addr + {20'h0, rng[9:0], 2'b00} + 32'd4;
            n = 0;
            while (flash_cs_n && n < TIMEOUT) begin
                @(negedge clk);
                n++;
            end
            check_true(!flash_cs_n, "fetch transfer never started");
            // Land somewhere inside the running fetch
            repeat (int'(rng[13:10])) @(negedge clk);
            psram_access(k[0]);
            wait_instr(ok);
            check_true(ok, "instr_ready never rose after an aborted fetch");
            check_value("instr_data", instr_data, flash_word(instr_addr));
        end
        end_test("abort", errors - test_start);

        end_test("cs_exclusive", cs_errors);
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
